/* Bender.yml */
package:
  name: spu_odd_pipe

export_include_dirs:
  - include

sources:
  - files:
      - hw/odd_pipe_pkg.sv
      - hw/ls_addr_gen.sv
      - hw/branch_unit.sv
      - hw/quad_permute.sv
      - hw/wb_pipe.sv
      - hw/odd_ctrl.sv
      - hw/odd_pipe.sv

  - target: test
    files:
      - test/odd_pipe_tb.sv

/* hw/branch_unit.sv */
// Branch unit
// Evaluates branch conditions and computes the target PC for relative,
// absolute, indirect and conditional branches; flags link-setting forms

`timescale 1ns/1ps
`default_nettype none

`include "odd_pipe_cfg.svh"

module branch_unit (
    input  wire odd_pipe_pkg::odd_issue_t issue,
    output odd_pipe_pkg::branch_res_t     br
);
    import odd_pipe_pkg::*;

    localparam word_t BR_MASK = {{(`ODD_WORD_W-`ODD_BR_ALIGN){1'b1}}, {`ODD_BR_ALIGN{1'b0}}};

    word_t imm_sh;
    word_t rel_tgt;
    word_t seq_pc;
    logic  word_nz;
    logic  half_nz;

    assign imm_sh  = {{(`ODD_WORD_W-18){issue.imm.i16.bits[0]}}, issue.imm.i16.bits, 2'b00};
    assign rel_tgt = issue.pc + imm_sh;
    assign seq_pc  = issue.pc + word_t'(4);

    // Conditions look at the preferred word of rc
    assign word_nz = |issue.rc[0:31];
    assign half_nz = |issue.rc[16:31];

    always_comb begin
        br.taken  = 1'b0;
        br.target = seq_pc;
        br.link   = 1'b0;
        case (issue.op)
            BRANCH_RELATIVE: begin
                br.taken  = 1'b1;
                br.target = rel_tgt;
            end
            BRANCH_ABSOLUTE: begin
                br.taken  = 1'b1;
                br.target = imm_sh;
            end
            BRANCH_INDIRECT: begin
                br.taken  = 1'b1;
                br.target = issue.ra[0:`ODD_WORD_W-1] & BR_MASK;
            end
            BRANCH_RELATIVE_AND_SET_LINK: begin
                br.taken  = 1'b1;
                br.target = rel_tgt;
                br.link   = 1'b1;
            end
            BRANCH_ABSOLUTE_AND_SET_LINK: begin
                br.taken  = 1'b1;
                br.target = imm_sh;
                br.link   = 1'b1;
            end
            BRANCH_IF_NOT_ZERO_WORD:     br.taken = word_nz;
            BRANCH_IF_ZERO_WORD:         br.taken = !word_nz;
            BRANCH_IF_NOT_ZERO_HALFWORD: br.taken = half_nz;
            BRANCH_IF_ZERO_HALFWORD:     br.taken = !half_nz;
            default: ;
        endcase
        // Taken conditionals go to the aligned relative target
        if (br.taken && (issue.op inside {BRANCH_IF_NOT_ZERO_WORD, BRANCH_IF_ZERO_WORD,
                BRANCH_IF_NOT_ZERO_HALFWORD, BRANCH_IF_ZERO_HALFWORD})) begin
            br.target = rel_tgt & BR_MASK;
        end
    end

endmodule

`default_nettype wire

/* hw/ls_addr_gen.sv */
// Local-store address generator
// Forms the quadword-aligned address for D-form and A-form loads and
// stores, and the write request for stores

`timescale 1ns/1ps
`default_nettype none

`include "odd_pipe_cfg.svh"

module ls_addr_gen (
    input  wire odd_pipe_pkg::odd_issue_t issue,
    output odd_pipe_pkg::ls_req_t         ls_req
);
    import odd_pipe_pkg::*;

    word_t d_off;
    word_t a_off;
    word_t raw_addr;
    logic  a_form;
    logic  store;

    // Immediate scaled to quadwords for D-form, to words for A-form
    assign d_off = {{(`ODD_WORD_W-10-`ODD_QW_ALIGN){issue.imm.i10.bits[0]}},
                    issue.imm.i10.bits, {`ODD_QW_ALIGN{1'b0}}};
    assign a_off = {{(`ODD_WORD_W-18){issue.imm.i16.bits[0]}}, issue.imm.i16.bits, 2'b00};

    assign a_form = (issue.op == LOAD_QUADWORD_AFORM) || (issue.op == STORE_QUADWORD_AFORM);
    assign store  = (issue.op == STORE_QUADWORD_DFORM) || (issue.op == STORE_QUADWORD_AFORM);

    assign raw_addr = a_form ? a_off : issue.ra[0:`ODD_WORD_W-1] + d_off;

    assign ls_req.we   = store;
    assign ls_req.addr = {raw_addr[0:`ODD_WORD_W-`ODD_QW_ALIGN-1], {`ODD_QW_ALIGN{1'b0}}};
    assign ls_req.data = issue.rc;

endmodule

`default_nettype wire

/* hw/odd_ctrl.sv */
// Odd pipeline control
// Classifies the issued opcode, forms the write-back word of the issue
// cycle and delays taken-branch redirects to the end of the pipe.
// The redirect flush also drives squash for the write-back pipe

`timescale 1ns/1ps
`default_nettype none

`include "odd_pipe_cfg.svh"

module odd_ctrl (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire odd_pipe_pkg::odd_issue_t    issue,
    input  wire odd_pipe_pkg::quad_t         ls_rdata,
    input  wire odd_pipe_pkg::branch_res_t   br,
    input  wire odd_pipe_pkg::quad_t         perm_result,
    output odd_pipe_pkg::wb_t                wb_in,
    output logic                             squash,
    output odd_pipe_pkg::redirect_t          redirect
);
    import odd_pipe_pkg::*;

    op_class_e             op_class;
    word_t                 link_word;
    logic [1:`ODD_DEPTH]   flush_q;
    word_t                 pc_q [1:`ODD_DEPTH];

    always_comb begin
        case (issue.op)
            LOAD_QUADWORD_DFORM, LOAD_QUADWORD_AFORM:   op_class = LOAD;
            STORE_QUADWORD_DFORM, STORE_QUADWORD_AFORM: op_class = STORE;
            BRANCH_RELATIVE, BRANCH_ABSOLUTE, BRANCH_INDIRECT,
            BRANCH_RELATIVE_AND_SET_LINK, BRANCH_ABSOLUTE_AND_SET_LINK,
            BRANCH_IF_NOT_ZERO_WORD, BRANCH_IF_ZERO_WORD,
            BRANCH_IF_NOT_ZERO_HALFWORD, BRANCH_IF_ZERO_HALFWORD:
                op_class = BRANCH;
            SHIFT_LEFT_QUADWORD_BY_BITS, SHIFT_LEFT_QUADWORD_BY_BITS_IMMEDIATE,
            SHIFT_LEFT_QUADWORD_BY_BYTES, SHIFT_LEFT_QUADWORD_BY_BYTES_IMMEDIATE,
            ROTATE_QUADWORD_BY_BITS, ROTATE_QUADWORD_BY_BITS_IMMEDIATE,
            ROTATE_QUADWORD_BY_BYTES, ROTATE_QUADWORD_BY_BYTES_IMMEDIATE:
                op_class = PERMUTE;
            default: op_class = NONE;
        endcase
    end

    // Link value lands in the preferred word
    assign link_word = issue.pc + word_t'(4);

    always_comb begin
        wb_in.addr = issue.rt_addr;
        wb_in.we   = (op_class == LOAD) || (op_class == PERMUTE) ||
                     ((op_class == BRANCH) && br.link);
        case (op_class)
            LOAD:    wb_in.data = ls_rdata;
            BRANCH:  wb_in.data = {link_word, {(`ODD_QUAD_W-`ODD_WORD_W){1'b0}}};
            PERMUTE: wb_in.data = perm_result;
            default: wb_in.data = '0;
        endcase
    end

    // Redirect delay line, the issue slot plus the youngest stages die on flush
    always_ff @(posedge clk) begin
        if (rst) begin
            flush_q <= '0;
        end else begin
            flush_q[1] <= br.taken && !squash;
            for (int i = 2; i <= `ODD_DEPTH; i++) begin
                flush_q[i] <= flush_q[i-1] && !(squash && (i <= `ODD_SQUASH + 1));
            end
        end
    end

    always_ff @(posedge clk) begin
        pc_q[1] <= br.target;
        for (int i = 2; i <= `ODD_DEPTH; i++) begin
            pc_q[i] <= pc_q[i-1];
        end
    end

    assign redirect = '{flush: flush_q[`ODD_DEPTH], pc: pc_q[`ODD_DEPTH]};
    assign squash   = redirect.flush;

    // One-cycle flush pulse per taken branch
    a_flush_pulse: assert property (@(posedge clk) disable iff (rst)
        redirect.flush |=> !redirect.flush);

endmodule

`default_nettype wire

/* hw/odd_pipe.sv */
// Odd pipeline top level
// Loads and stores, branches and quadword permutes of an SPU-style core,
// joined to a fixed-depth write-back and redirect pipe

`timescale 1ns/1ps
`default_nettype none

module odd_pipe (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire odd_pipe_pkg::odd_issue_t issue,
    input  wire odd_pipe_pkg::quad_t      ls_rdata,
    output odd_pipe_pkg::ls_req_t         ls_req,
    output odd_pipe_pkg::wb_t             wb,
    output odd_pipe_pkg::redirect_t       redirect
);
    import odd_pipe_pkg::*;

    branch_res_t br;
    quad_t       perm_result;
    wb_t         wb_in;
    logic        squash;

    odd_ctrl i_odd_ctrl (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .ls_rdata    (ls_rdata),
        .br          (br),
        .perm_result (perm_result),
        .wb_in       (wb_in),
        .squash      (squash),
        .redirect    (redirect)
    );

    ls_addr_gen i_ls_addr_gen (
        .issue  (issue),
        .ls_req (ls_req)
    );

    branch_unit i_branch_unit (
        .issue (issue),
        .br    (br)
    );

    quad_permute i_quad_permute (
        .issue  (issue),
        .result (perm_result)
    );

    wb_pipe i_wb_pipe (
        .clk    (clk),
        .rst    (rst),
        .wb_in  (wb_in),
        .squash (squash),
        .wb     (wb)
    );

endmodule

`default_nettype wire

/* hw/odd_pipe_pkg.sv */
// Odd pipeline package
// Opcodes, immediate views and the structs passed between the odd-pipe
// blocks. Bit 0 is the most significant bit throughout

`default_nettype none

package odd_pipe_pkg;

    `include "odd_pipe_cfg.svh"

    typedef logic [0:`ODD_QUAD_W-1]     quad_t;
    typedef logic [0:`ODD_WORD_W-1]     word_t;
    typedef logic [0:`ODD_REG_ADDR_W-1] reg_addr_t;

    typedef enum logic [4:0] {
        NOP,
        LOAD_QUADWORD_DFORM,
        LOAD_QUADWORD_AFORM,
        STORE_QUADWORD_DFORM,
        STORE_QUADWORD_AFORM,
        BRANCH_RELATIVE,
        BRANCH_ABSOLUTE,
        BRANCH_INDIRECT,
        BRANCH_RELATIVE_AND_SET_LINK,
        BRANCH_ABSOLUTE_AND_SET_LINK,
        BRANCH_IF_NOT_ZERO_WORD,
        BRANCH_IF_ZERO_WORD,
        BRANCH_IF_NOT_ZERO_HALFWORD,
        BRANCH_IF_ZERO_HALFWORD,
        SHIFT_LEFT_QUADWORD_BY_BITS,
        SHIFT_LEFT_QUADWORD_BY_BITS_IMMEDIATE,
        SHIFT_LEFT_QUADWORD_BY_BYTES,
        SHIFT_LEFT_QUADWORD_BY_BYTES_IMMEDIATE,
        ROTATE_QUADWORD_BY_BITS,
        ROTATE_QUADWORD_BY_BITS_IMMEDIATE,
        ROTATE_QUADWORD_BY_BYTES,
        ROTATE_QUADWORD_BY_BYTES_IMMEDIATE
    } odd_op_e;

    // A-form and branch view
    typedef struct packed {
        logic [0:`ODD_IMM_W-17] pad;
        logic [0:15]            bits;
    } imm16_t;

    // D-form view, the shifter takes its 7-bit count from the low end
    typedef struct packed {
        logic [0:`ODD_IMM_W-11] pad;
        logic [0:9]             bits;
    } imm10_t;

    typedef union packed {
        imm16_t i16;
        imm10_t i10;
    } imm_u;

    typedef enum logic [2:0] {
        NONE,
        LOAD,
        STORE,
        BRANCH,
        PERMUTE
    } op_class_e;

    typedef struct packed {
        odd_op_e   op;
        quad_t     ra;
        quad_t     rb;
        quad_t     rc;
        imm_u      imm;
        reg_addr_t rt_addr;
        word_t     pc;
    } odd_issue_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        quad_t     data;
    } wb_t;

    typedef struct packed {
        logic  we;
        word_t addr;
        quad_t data;
    } ls_req_t;

    typedef struct packed {
        logic  flush;
        word_t pc;
    } redirect_t;

    typedef struct packed {
        logic  taken;
        word_t target;
        logic  link;
    } branch_res_t;

endpackage

`default_nettype wire

/* hw/quad_permute.sv */
// Quadword permute unit
// Shift left and rotate left of a full quadword by bits or bytes,
// with the count from rb or the immediate, on a log shifter

`timescale 1ns/1ps
`default_nettype none

`include "odd_pipe_cfg.svh"

module quad_permute (
    input  wire odd_pipe_pkg::odd_issue_t issue,
    output odd_pipe_pkg::quad_t           result
);
    import odd_pipe_pkg::*;

    localparam int SH_W = $clog2(`ODD_QUAD_W);

    logic [0:6]      imm7;
    logic [0:2]      bit_cnt;
    logic [0:4]      byte_cnt;
    logic [SH_W-1:0] amt;
    logic            use_imm;
    logic            by_bytes;
    logic            rotate;

    function automatic quad_t log_shift(quad_t v, logic [SH_W-1:0] n, logic rot);
        quad_t r;
        r = v;
        for (int j = 0; j < SH_W; j++) begin
            if (n[j]) begin
                r = rot ? ((r << (1 << j)) | (r >> (`ODD_QUAD_W - (1 << j))))
                        : (r << (1 << j));
            end
        end
        return r;
    endfunction

    always_comb begin
        use_imm  = 1'b0;
        by_bytes = 1'b0;
        rotate   = 1'b0;
        case (issue.op)
            SHIFT_LEFT_QUADWORD_BY_BITS_IMMEDIATE: use_imm = 1'b1;
            SHIFT_LEFT_QUADWORD_BY_BYTES:          by_bytes = 1'b1;
            SHIFT_LEFT_QUADWORD_BY_BYTES_IMMEDIATE: begin
                use_imm  = 1'b1;
                by_bytes = 1'b1;
            end
            ROTATE_QUADWORD_BY_BITS:               rotate = 1'b1;
            ROTATE_QUADWORD_BY_BITS_IMMEDIATE: begin
                use_imm = 1'b1;
                rotate  = 1'b1;
            end
            ROTATE_QUADWORD_BY_BYTES: begin
                by_bytes = 1'b1;
                rotate   = 1'b1;
            end
            ROTATE_QUADWORD_BY_BYTES_IMMEDIATE: begin
                use_imm  = 1'b1;
                by_bytes = 1'b1;
                rotate   = 1'b1;
            end
            default: ;
        endcase
    end

    assign imm7     = issue.imm.i10.bits[3:9];
    assign bit_cnt  = use_imm ? imm7[4:6] : issue.rb[29:31];
    assign byte_cnt = use_imm ? imm7[2:6] : issue.rb[27:31];

    // Byte counts below 16 scale to a bit count
    assign amt = by_bytes ? {byte_cnt[1:4], 3'b000} : {4'b0000, bit_cnt};

    assign result = (by_bytes && byte_cnt[0]) ? '0 : log_shift(issue.ra, amt, rotate);

endmodule

`default_nettype wire

/* hw/wb_pipe.sv */
// Write-back pipeline
// Carries each result through the fixed-depth odd pipe to the register
// file; a squash kills the incoming entry and the youngest stages

`timescale 1ns/1ps
`default_nettype none

`include "odd_pipe_cfg.svh"

module wb_pipe (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire odd_pipe_pkg::wb_t wb_in,
    input  wire logic              squash,
    output odd_pipe_pkg::wb_t      wb
);
    import odd_pipe_pkg::*;

    logic [1:`ODD_DEPTH] we_q;
    reg_addr_t           addr_q [1:`ODD_DEPTH];
    quad_t               data_q [1:`ODD_DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            we_q <= '0;
        end else begin
            we_q[1] <= wb_in.we && !squash;
            for (int i = 2; i <= `ODD_DEPTH; i++) begin
                // Older stages keep moving during a squash
                we_q[i] <= we_q[i-1] && !(squash && (i <= `ODD_SQUASH + 1));
            end
        end
    end

    always_ff @(posedge clk) begin
        addr_q[1] <= wb_in.addr;
        data_q[1] <= wb_in.data;
        for (int i = 2; i <= `ODD_DEPTH; i++) begin
            addr_q[i] <= addr_q[i-1];
            data_q[i] <= data_q[i-1];
        end
    end

    assign wb = '{we: we_q[`ODD_DEPTH], addr: addr_q[`ODD_DEPTH], data: data_q[`ODD_DEPTH]};

    a_we_after_rst: assert property (@(posedge clk) rst |=> !wb.we);

endmodule

`default_nettype wire

/* include/odd_pipe_cfg.svh */
// Odd pipeline configuration
// Datapath widths, pipeline depth and address alignment shared by the
// odd-pipe RTL and its package

`ifndef ODD_PIPE_CFG_SVH
`define ODD_PIPE_CFG_SVH

// Register and word widths
`define ODD_QUAD_W      128
`define ODD_WORD_W      32
`define ODD_REG_ADDR_W  7

// Raw immediate field as carried with the instruction
`define ODD_IMM_W       18

// Issue to write-back and redirect latency
`define ODD_DEPTH       7

// Youngest stages killed by a taken branch
`define ODD_SQUASH      3

// Local store works on 16-byte quadwords
`define ODD_QW_ALIGN    4

// Instruction words are 4-byte aligned
`define ODD_BR_ALIGN    2

`endif

/* spu_odd_pipe.f */
+incdir+include
hw/odd_pipe_pkg.sv
hw/ls_addr_gen.sv
hw/branch_unit.sv
hw/quad_permute.sv
hw/wb_pipe.sv
hw/odd_ctrl.sv
hw/odd_pipe.sv
test/odd_pipe_tb.sv

/* test/odd_pipe_tb.sv */
// Odd pipeline testbench
// Directed tests for reset, loads and stores, quadword permutes, branches
// and the flush squash, checked against a model of the pipe's rules

`timescale 1ns/1ps
`default_nettype none

`include "odd_pipe_cfg.svh"

module odd_pipe_tb;
    import odd_pipe_pkg::*;

    localparam int    IDLE_LIMIT = 40;
    localparam word_t QW_MASK    = ~((32'd1 << `ODD_QW_ALIGN) - 32'd1);
    localparam word_t BR_MASK    = ~((32'd1 << `ODD_BR_ALIGN) - 32'd1);

    logic       clk;
    logic       rst;
    odd_issue_t issue;
    quad_t      ls_rdata;
    ls_req_t    ls_req;
    wb_t        wb;
    redirect_t  redirect;

    int tests;
    int checks;
    int errors;
    int test_errs;

    // Program of one run and what it should produce
    odd_issue_t prog_q [$];
    quad_t      rdata_q [$];
    ls_req_t    exp_ls_q [$];
    bit         exp_ls_addr_q [$];
    wb_t        exp_wb_q [$];
    int         exp_wb_at [$];
    word_t      exp_pc_q [$];
    int         exp_pc_at [$];

    // Observed DUT outputs
    ls_req_t    got_ls_q [$];
    wb_t        got_wb_q [$];
    int         got_wb_at [$];
    word_t      got_pc_q [$];
    int         got_pc_at [$];

    odd_pipe i_odd_pipe (
        .clk      (clk),
        .rst      (rst),
        .issue    (issue),
        .ls_rdata (ls_rdata),
        .ls_req   (ls_req),
        .wb       (wb),
        .redirect (redirect)
    );

    always #50 clk = ~clk;

    function automatic odd_issue_t nop_issue();
        odd_issue_t ins;
        ins    = '0;
        ins.op = NOP;
        return ins;
    endfunction

    function automatic quad_t rand_quad();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    // Sign-extended 16-bit immediate in words
    function automatic word_t word_off16(logic [15:0] v);
        return {{16{v[15]}}, v} << 2;
    endfunction

    function automatic word_t dform_addr(word_t base, logic [9:0] v);
        word_t off;
        off = {{22{v[9]}}, v} << 4;
        return (base + off) & QW_MASK;
    endfunction

    // Bit i of the result takes bit i+n of the source, bit 0 is the MSB
    function automatic quad_t move_left(quad_t v, int n, bit rot);
        quad_t r;
        int    src;
        for (int i = 0; i < `ODD_QUAD_W; i++) begin
            src = i + n;
            if (src < `ODD_QUAD_W) begin
                r[i] = v[src];
            end else if (rot) begin
                r[i] = v[src - `ODD_QUAD_W];
            end else begin
                r[i] = 1'b0;
            end
        end
        return r;
    endfunction

    task automatic report_err(string msg);
        errors++;
        test_errs++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    task automatic wait_idle();
        int quiet;
        bit done;
        quiet    = 0;
        done     = 0;
        issue    = nop_issue();
        ls_rdata = '0;
        for (int c = 0; c < IDLE_LIMIT && !done; c++) begin
            @(posedge clk);
            #1;
            if (wb.we || redirect.flush) begin
                quiet = 0;
            end else begin
                quiet++;
            end
            done = (quiet >= `ODD_DEPTH);
        end
        if (!done) begin
            errors++;
            test_errs++;
            $display("Pipeline did not go idle within %0d cycles", IDLE_LIMIT);
        end
    endtask

    task automatic start_test();
        test_errs = 0;
        wait_idle();
    endtask

    task automatic end_test(string name);
        tests++;
        $display("test %-10s %s, %0d errors", name, (test_errs == 0) ? "passed" : "failed",
                 test_errs);
    endtask

    task automatic clear_prog();
        prog_q.delete();
        rdata_q.delete();
        exp_ls_q.delete();
        exp_ls_addr_q.delete();
        exp_wb_q.delete();
        exp_wb_at.delete();
        exp_pc_q.delete();
        exp_pc_at.delete();
    endtask

    task automatic add_instr(odd_issue_t ins, quad_t rdata, ls_req_t exp, bit chk_addr);
        prog_q.push_back(ins);
        rdata_q.push_back(rdata);
        exp_ls_q.push_back(exp);
        exp_ls_addr_q.push_back(chk_addr);
    endtask

    // The issue edge is the first of the DEPTH edges to the output
    task automatic expect_wb(reg_addr_t addr, quad_t data);
        wb_t w;
        w.we   = 1'b1;
        w.addr = addr;
        w.data = data;
        exp_wb_q.push_back(w);
        exp_wb_at.push_back(prog_q.size() - 1 + `ODD_DEPTH - 1);
    endtask

    task automatic expect_redirect(word_t pc);
        exp_pc_q.push_back(pc);
        exp_pc_at.push_back(prog_q.size() - 1 + `ODD_DEPTH - 1);
    endtask

    // One instruction per cycle, then NOPs until everything has drained
    task automatic run_prog();
        int n;
        n = prog_q.size() + `ODD_DEPTH + 1;
        got_ls_q.delete();
        got_wb_q.delete();
        got_wb_at.delete();
        got_pc_q.delete();
        got_pc_at.delete();
        for (int t = 0; t < n; t++) begin
            if (t < prog_q.size()) begin
                issue    = prog_q[t];
                ls_rdata = rdata_q[t];
            end else begin
                issue    = nop_issue();
                ls_rdata = '0;
            end
            #10;
            if (t < prog_q.size()) begin
                got_ls_q.push_back(ls_req);
            end
            @(posedge clk);
            #1;
            if (wb.we) begin
                got_wb_q.push_back(wb);
                got_wb_at.push_back(t);
            end
            if (redirect.flush) begin
                got_pc_q.push_back(redirect.pc);
                got_pc_at.push_back(t);
            end
        end
        issue    = nop_issue();
        ls_rdata = '0;
    endtask

    task automatic check_logs();
        for (int i = 0; i < exp_ls_q.size(); i++) begin
            checks++;
            if (got_ls_q[i].we !== exp_ls_q[i].we) begin
                report_err($sformatf("op %0d ls_req.we %b, expected %b", i,
                                     got_ls_q[i].we, exp_ls_q[i].we));
            end
            if (exp_ls_addr_q[i] && got_ls_q[i].addr !== exp_ls_q[i].addr) begin
                report_err($sformatf("op %0d ls_req.addr %h, expected %h", i,
                                     got_ls_q[i].addr, exp_ls_q[i].addr));
            end
            if (exp_ls_q[i].we && got_ls_q[i].data !== exp_ls_q[i].data) begin
                report_err($sformatf("op %0d ls_req.data %h, expected %h", i,
                                     got_ls_q[i].data, exp_ls_q[i].data));
            end
        end
        checks++;
        if (got_wb_q.size() != exp_wb_q.size()) begin
            report_err($sformatf("%0d write-backs, expected %0d", got_wb_q.size(),
                                 exp_wb_q.size()));
        end
        for (int i = 0; i < got_wb_q.size() && i < exp_wb_q.size(); i++) begin
            checks++;
            if (got_wb_at[i] != exp_wb_at[i] || got_wb_q[i].addr !== exp_wb_q[i].addr ||
                    got_wb_q[i].data !== exp_wb_q[i].data) begin
                report_err($sformatf("wb %0d cycle %0d reg %0d data %h, expected %0d %0d %h",
                                     i, got_wb_at[i], got_wb_q[i].addr, got_wb_q[i].data,
                                     exp_wb_at[i], exp_wb_q[i].addr, exp_wb_q[i].data));
            end
        end
        checks++;
        if (got_pc_q.size() != exp_pc_q.size()) begin
            report_err($sformatf("%0d flushes, expected %0d", got_pc_q.size(),
                                 exp_pc_q.size()));
        end
        for (int i = 0; i < got_pc_q.size() && i < exp_pc_q.size(); i++) begin
            checks++;
            if (got_pc_at[i] != exp_pc_at[i] || got_pc_q[i] !== exp_pc_q[i]) begin
                report_err($sformatf("flush %0d cycle %0d pc %h, expected cycle %0d pc %h",
                                     i, got_pc_at[i], got_pc_q[i], exp_pc_at[i],
                                     exp_pc_q[i]));
            end
        end
    endtask

    task automatic test_reset();
        ls_req_t exp;
        test_errs = 0;
        checks++;
        if (wb.we !== 1'b0 || redirect.flush !== 1'b0 || ls_req.we !== 1'b0) begin
            report_err($sformatf("after reset wb.we %b flush %b ls_req.we %b", wb.we,
                                 redirect.flush, ls_req.we));
        end
        exp = '0;
        clear_prog();
        for (int t = 0; t < 4; t++) begin
            add_instr(nop_issue(), rand_quad(), exp, 1'b0);
        end
        run_prog();
        check_logs();
        end_test("reset");
    endtask

    task automatic test_ld_st();
        odd_issue_t  ins;
        ls_req_t     exp;
        quad_t       rd;
        logic [9:0]  imm10;
        logic [15:0] imm16;
        start_test();
        clear_prog();
        for (int j = 0; j < 2; j++) begin
            ins         = nop_issue();
            ins.ra      = rand_quad();
            ins.rc      = rand_quad();
            ins.rt_addr = 7'(10 + j);
            imm10       = 10'($urandom());
            imm16       = 16'($urandom());
            rd          = rand_quad();
            // D-form load and store
            ins.imm  = imm_u'({8'h00, imm10});
            exp      = '0;
            exp.addr = dform_addr(ins.ra[0:`ODD_WORD_W-1], imm10);
            ins.op   = LOAD_QUADWORD_DFORM;
            add_instr(ins, rd, exp, 1'b1);
            expect_wb(ins.rt_addr, rd);
            ins.op   = STORE_QUADWORD_DFORM;
            exp.we   = 1'b1;
            exp.data = ins.rc;
            add_instr(ins, rand_quad(), exp, 1'b1);
            // A-form load and store
            ins.imm  = imm_u'({2'b00, imm16});
            exp      = '0;
            exp.addr = word_off16(imm16) & QW_MASK;
            ins.op   = LOAD_QUADWORD_AFORM;
            add_instr(ins, rd, exp, 1'b1);
            expect_wb(ins.rt_addr, rd);
            ins.op   = STORE_QUADWORD_AFORM;
            exp.we   = 1'b1;
            exp.data = ins.rc;
            add_instr(ins, rand_quad(), exp, 1'b1);
        end
        run_prog();
        check_logs();
        end_test("ld_st");
    endtask

    task automatic test_permute();
        odd_op_e     ops [8];
        odd_issue_t  ins;
        ls_req_t     exp;
        quad_t       res;
        logic [17:0] imm;
        int          cnt;
        bit          use_imm;
        bit          by_bytes;
        bit          rot;
        start_test();
        ops = '{SHIFT_LEFT_QUADWORD_BY_BITS, SHIFT_LEFT_QUADWORD_BY_BITS_IMMEDIATE,
                SHIFT_LEFT_QUADWORD_BY_BYTES, SHIFT_LEFT_QUADWORD_BY_BYTES_IMMEDIATE,
                ROTATE_QUADWORD_BY_BITS, ROTATE_QUADWORD_BY_BITS_IMMEDIATE,
                ROTATE_QUADWORD_BY_BYTES, ROTATE_QUADWORD_BY_BYTES_IMMEDIATE};
        exp = '0;
        clear_prog();
        for (int k = 0; k < 8; k++) begin
            // Form flags follow the order of the list
            use_imm  = k[0];
            by_bytes = k[1];
            rot      = k[2];
            for (int j = 0; j < 3; j++) begin
                ins         = nop_issue();
                ins.op      = ops[k];
                ins.ra      = rand_quad();
                ins.rb      = rand_quad();
                ins.rt_addr = 7'(k * 3 + j);
                imm         = 18'($urandom());
                if (by_bytes) begin
                    // Second case of each byte form always has a count of 16 or more
                    cnt = (j == 1) ? 16 + ($urandom() % 16) : $urandom() % 32;
                    if (use_imm) begin
                        imm[4:0] = 5'(cnt);
                    end else begin
                        ins.rb[27:31] = 5'(cnt);
                    end
                    res = (cnt >= 16) ? '0 : move_left(ins.ra, cnt * 8, rot);
                end else begin
                    cnt = $urandom() % 8;
                    if (use_imm) begin
                        imm[2:0] = 3'(cnt);
                    end else begin
                        ins.rb[29:31] = 3'(cnt);
                    end
                    res = move_left(ins.ra, cnt, rot);
                end
                ins.imm = imm_u'(imm);
                add_instr(ins, rand_quad(), exp, 1'b0);
                expect_wb(ins.rt_addr, res);
            end
        end
        run_prog();
        check_logs();
        end_test("permute");
    endtask

    task automatic branch_case(odd_op_e op, quad_t rc);
        odd_issue_t  ins;
        ls_req_t     exp;
        logic [15:0] imm16;
        word_t       rel;
        word_t       tgt;
        bit          taken;
        bit          link;
        ins         = nop_issue();
        ins.op      = op;
        ins.ra      = rand_quad();
        ins.rc      = rc;
        ins.pc      = $urandom();
        ins.rt_addr = 7'($urandom());
        imm16       = 16'($urandom());
        ins.imm     = imm_u'({2'b00, imm16});
        rel         = ins.pc + word_off16(imm16);
        taken       = 1'b1;
        link        = 1'b0;
        tgt         = rel & BR_MASK;
        case (op)
            BRANCH_RELATIVE:              tgt = rel;
            BRANCH_ABSOLUTE:              tgt = word_off16(imm16);
            BRANCH_INDIRECT:              tgt = ins.ra[0:`ODD_WORD_W-1] & BR_MASK;
            BRANCH_RELATIVE_AND_SET_LINK: begin
                tgt  = rel;
                link = 1'b1;
            end
            BRANCH_ABSOLUTE_AND_SET_LINK: begin
                tgt  = word_off16(imm16);
                link = 1'b1;
            end
            BRANCH_IF_NOT_ZERO_WORD:      taken = (rc[0:31] != '0);
            BRANCH_IF_ZERO_WORD:          taken = (rc[0:31] == '0);
            BRANCH_IF_NOT_ZERO_HALFWORD:  taken = (rc[16:31] != '0);
            BRANCH_IF_ZERO_HALFWORD:      taken = (rc[16:31] == '0);
            default:                      taken = 1'b0;
        endcase
        exp = '0;
        clear_prog();
        add_instr(ins, rand_quad(), exp, 1'b0);
        if (taken) begin
            expect_redirect(tgt);
        end
        if (link) begin
            expect_wb(ins.rt_addr, {ins.pc + 32'd4, {(`ODD_QUAD_W-`ODD_WORD_W){1'b0}}});
        end
        run_prog();
        check_logs();
        wait_idle();
    endtask

    task automatic test_branch();
        quad_t rc;
        start_test();
        branch_case(BRANCH_RELATIVE, rand_quad());
        branch_case(BRANCH_ABSOLUTE, rand_quad());
        branch_case(BRANCH_INDIRECT, rand_quad());
        branch_case(BRANCH_RELATIVE_AND_SET_LINK, rand_quad());
        branch_case(BRANCH_ABSOLUTE_AND_SET_LINK, rand_quad());
        for (int k = 0; k < 2; k++) begin
            rc = rand_quad();
            if (k == 0) begin
                rc[0:31] = '0;
            end else begin
                rc[31] = 1'b1;
            end
            branch_case(BRANCH_IF_NOT_ZERO_WORD, rc);
            branch_case(BRANCH_IF_ZERO_WORD, rc);
            // Upper halfword set so only bits 16 to 31 decide
            rc    = rand_quad();
            rc[0] = 1'b1;
            if (k == 0) begin
                rc[16:31] = '0;
            end else begin
                rc[31] = 1'b1;
            end
            branch_case(BRANCH_IF_NOT_ZERO_HALFWORD, rc);
            branch_case(BRANCH_IF_ZERO_HALFWORD, rc);
        end
        end_test("branch");
    endtask

    task automatic test_squash();
        odd_issue_t  ins;
        ls_req_t     exp;
        quad_t       rd;
        logic [15:0] imm16;
        int          flush_at;
        start_test();
        clear_prog();
        // Branch in slot 1, the flush shows up DEPTH edges after its issue edge
        flush_at = 1 + `ODD_DEPTH - 1;
        for (int t = 0; t < 10; t++) begin
            ins     = nop_issue();
            imm16   = 16'($urandom());
            ins.imm = imm_u'({2'b00, imm16});
            ins.pc  = $urandom();
            rd      = rand_quad();
            exp     = '0;
            if (t == 1) begin
                ins.op = BRANCH_RELATIVE;
                add_instr(ins, rd, exp, 1'b0);
                expect_redirect(ins.pc + word_off16(imm16));
            end else begin
                ins.op      = LOAD_QUADWORD_AFORM;
                ins.rt_addr = 7'(32 + t);
                exp.addr    = word_off16(imm16) & QW_MASK;
                add_instr(ins, rd, exp, 1'b1);
                // Young stages and the issue slot of the flush cycle are lost
                if (t < flush_at - `ODD_SQUASH + 1 || t > flush_at + 1) begin
                    expect_wb(ins.rt_addr, rd);
                end
            end
        end
        run_prog();
        check_logs();
        end_test("squash");
    endtask

    initial begin
        void'($urandom(32'h1e8f_37bc));
        clk       = 1'b0;
        rst       = 1'b1;
        issue     = nop_issue();
        ls_rdata  = '0;
        tests     = 0;
        checks    = 0;
        errors    = 0;
        test_errs = 0;
        for (int i = 0; i < 2; i++) begin
            @(posedge clk);
        end
        #1;
        rst = 1'b0;
        test_reset();
        test_ld_st();
        test_permute();
        test_branch();
        test_squash();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
